// File: filelist.f
hdl/regFilePkg.sv
hdl/regCmdIf.sv
hdl/operandSelect.sv
hdl/registerFile.sv
hdl/regAccessTop.sv
testbench/regAccessTb_assertions.sv
testbench/regAccessTb.sv

// File: testbench/regAccessTb.sv
`timescale 1ns/1ps

module regAccessTb;
	import regFilePkg::*;

	typedef struct {
		dataSelA dataSrcA;
		addrSelA addrSrcA;
		addrSelB addrSrcB;
		regAddr argA, argB;
		logic enA, weA, enB, weB;
		byteLanes byteEnA, byteEnB;
		logic [wordWidth-1:0] dataIn, aluResult, pcNext, expA, expB;
	} cmdEntry;

	localparam int timeoutCycles = 100;

	logic CLK;
	logic reset;
	logic cmdReq;
	logic cmdAck;
	logic rspReq;
	logic rspAck;
	logic [wordWidth-1:0] dataIn, aluResult, pcNext;
	logic [wordWidth-1:0] doutA, doutB;
	logic enA, weA, enB, weB;
	regAddr argA, argB;
	dataSelA dataSrcA;
	addrSelA addrSrcA;
	addrSelB addrSrcB;
	byteLanes byteEnA, byteEnB;
	cmdEntry cmdTable[$];
	integer seed;

	regAccessTop dut_i (
		.dataSelA(dataSrcA),
		.addrSelA(addrSrcA),
		.addrSelB(addrSrcB),
		.*
	);

	always #4 CLK = ~CLK;

	// ******************************
	// helpers
	// ******************************

	task automatic stopRun();
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic checkValue(input logic [wordWidth-1:0] actual,
		input logic [wordWidth-1:0] expected, input string what);
		if (actual !== expected) begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
			stopRun();
		end
	endtask

	task automatic waitCmdAck(input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(posedge CLK);
			cycles++;
			if (cycles > timeoutCycles) begin
				$display("timeout while waiting for cmdAck to become %0b", level);
				stopRun();
			end
		end while (cmdAck !== level);
	endtask

	task automatic waitRspReq(input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(posedge CLK);
			cycles++;
			if (cycles > timeoutCycles) begin
				$display("timeout while waiting for rspReq to become %0b", level);
				stopRun();
			end
		end while (rspReq !== level);
	endtask

	// port A controls, port B controls, then dataIn, aluResult, pcNext, expected doutA, doutB.
	task automatic addEntry(input dataSelA ds, input addrSelA sa, input regAddr ra, input logic ea,
		input logic wa, input byteLanes ba, input addrSelB sb, input regAddr rb, input logic eb,
		input logic wb, input byteLanes bb, input logic [wordWidth-1:0] din,
		input logic [wordWidth-1:0] alu, input logic [wordWidth-1:0] pc,
		input logic [wordWidth-1:0] xa, input logic [wordWidth-1:0] xb);
		cmdEntry e;
		e = '{ds, sa, sb, ra, rb, ea, wa, eb, wb, ba, bb, din, alu, pc, xa, xb};
		cmdTable.push_back(e);
	endtask

	task automatic sendCommand(input cmdEntry e);
		dataIn <= e.dataIn;
		aluResult <= e.aluResult;
		pcNext <= e.pcNext;
		dataSrcA <= e.dataSrcA;
		addrSrcA <= e.addrSrcA;
		addrSrcB <= e.addrSrcB;
		{argA, enA, weA, byteEnA} <= {e.argA, e.enA, e.weA, e.byteEnA};
		{argB, enB, weB, byteEnB} <= {e.argB, e.enB, e.weB, e.byteEnB};
		cmdReq <= 1'b1;
		waitCmdAck(1'b1);
		cmdReq <= 1'b0;
		waitCmdAck(1'b0);
	endtask

	// ******************************
	// command table
	// ******************************

	task automatic buildTable();
		// every register starts at zero after reset.
		for (int i = 0; i < 8; i++) begin
			addEntry(dinSel, argASel, regAddr'(i), 1, 0, 2'b11, argBSel, regAddr'(i + 8), 1, 0,
				2'b11, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
		end
		addEntry(dinSel, argASel, 4, 1, 1, 2'b11, argBSel, 0, 0, 0, 2'b00,
			16'h1234, 16'h0000, 16'h0000, 16'h1234, 16'h0000);
		addEntry(dinHighSel, raSel, 0, 1, 1, 2'b11, argBSel, 0, 0, 0, 2'b00,
			16'hAB55, 16'h0000, 16'h0000, 16'h00AB, 16'h0000);
		addEntry(pcNextSel, rbSel, 0, 1, 1, 2'b11, argBSel, 4, 1, 0, 2'b11,
			16'h0000, 16'h0000, 16'h0420, 16'h0420, 16'h1234);
		addEntry(aluSel, rlSel, 0, 1, 1, 2'b11, argBSel, 1, 1, 0, 2'b11,
			16'h0000, 16'hBEEF, 16'h0000, 16'hBEEF, 16'h00AB);
		// port B writes to its fixed registers.
		addEntry(dinSel, raSel, 0, 1, 0, 2'b11, rspSel, 0, 1, 1, 2'b11,
			16'h0000, 16'h5A5A, 16'h0000, 16'h00AB, 16'h5A5A);
		addEntry(dinSel, argASel, 0, 0, 0, 2'b11, rfpSel, 0, 1, 1, 2'b11,
			16'h0000, 16'hC001, 16'h0000, 16'h00AB, 16'hC001);
		addEntry(dinSel, rbSel, 0, 1, 0, 2'b11, rrsSel, 0, 1, 1, 2'b11,
			16'h0000, 16'h7777, 16'h0000, 16'h0420, 16'h7777);
		addEntry(dinSel, rlSel, 0, 1, 0, 2'b11, rbSelB, 0, 1, 1, 2'b11,
			16'h0000, 16'h0BB0, 16'h0000, 16'hBEEF, 16'h0BB0);
		// both ports hit one register, so port B wins.
		addEntry(dinSel, argASel, 6, 1, 1, 2'b11, argBSel, 6, 1, 1, 2'b11,
			16'h1111, 16'h2222, 16'h0000, 16'h2222, 16'h2222);
		addEntry(dinSel, rbSel, 0, 1, 1, 2'b11, rbSelB, 0, 1, 1, 2'b11,
			16'h3333, 16'h4444, 16'h0000, 16'h4444, 16'h4444);
		// single byte lanes.
		addEntry(dinSel, argASel, 4, 1, 1, 2'b01, argBSel, 0, 0, 0, 2'b00,
			16'hFFCD, 16'h0000, 16'h0000, 16'h12CD, 16'h4444);
		addEntry(dinSel, argASel, 4, 1, 0, 2'b11, rspSel, 0, 1, 1, 2'b10,
			16'h0000, 16'h99FF, 16'h0000, 16'h12CD, 16'h995A);
		// writes through disabled ports leave the storage alone.
		addEntry(dinSel, argASel, 7, 0, 1, 2'b11, argBSel, 8, 0, 1, 2'b11,
			16'hDEAD, 16'hDEAD, 16'h0000, 16'h12CD, 16'h995A);
		addEntry(dinSel, argASel, 7, 1, 0, 2'b11, addrSelB'(3'd5), 8, 1, 0, 2'b11,
			16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
		addEntry(dinSel, argASel, 2, 1, 0, 2'b11, rfpSel, 0, 1, 0, 2'b11,
			16'h0000, 16'h0000, 16'h0000, 16'h4444, 16'hC001);
		addEntry(dinSel, argASel, 13, 1, 0, 2'b11, rrsSel, 0, 1, 0, 2'b11,
			16'h0000, 16'h0000, 16'h0000, 16'h995A, 16'h7777);
	endtask

	initial begin
		CLK = 1'b0;
		reset = 1'b1;
		cmdReq = 1'b0;
		rspAck = 1'b0;
		{dataIn, aluResult, pcNext} = '0;
		{enA, weA, enB, weB, argA, argB, byteEnA, byteEnB} = '0;
		dataSrcA = dinSel;
		addrSrcA = argASel;
		addrSrcB = argBSel;
		seed = 32'h424d;
		buildTable();
		repeat (16) @(posedge CLK);
		reset <= 1'b0;
		@(posedge CLK);
		fork
			foreach (cmdTable[i]) sendCommand(cmdTable[i]);
			// the consumer side delays each rspAck at random to stall the pipeline.
			for (int n = 0; n < cmdTable.size(); n++) begin
				waitRspReq(1'b1);
				checkValue(doutA, cmdTable[n].expA, $sformatf("entry %0d doutA", n));
				checkValue(doutB, cmdTable[n].expB, $sformatf("entry %0d doutB", n));
				repeat ({$random(seed)} % 4) @(posedge CLK);
				rspAck <= 1'b1;
				waitRspReq(1'b0);
				rspAck <= 1'b0;
			end
		join
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: testbench/regAccessTb_assertions.sv
`timescale 1ns/1ps

module regAccessTb_assertions (
	input logic CLK,
	input logic reset,
	input logic cmdReq,
	input logic cmdAck,
	input logic rspReq,
	input logic rspAck,
	input logic [regFilePkg::wordWidth-1:0] doutA,
	input logic [regFilePkg::wordWidth-1:0] doutB
);

	// cmdAck only ever answers a request that is present.
	ackFollowsReq: assert property (@(posedge CLK) disable iff (reset)
		$rose(cmdAck) |-> $past(cmdReq))
		else $error("cmdAck rose while cmdReq was low");

	// a response stays offered until the consumer takes it.
	rspHeldUntilAck: assert property (@(posedge CLK) disable iff (reset)
		rspReq && !rspAck |=> rspReq)
		else $error("rspReq dropped before rspAck");

	// the result words must not move under a pending response.
	doutStable: assert property (@(posedge CLK) disable iff (reset)
		rspReq && $past(rspReq) |-> $stable(doutA) && $stable(doutB))
		else $error("doutA or doutB changed while rspReq was high");

endmodule

bind regAccessTop regAccessTb_assertions handshakeChecks_i (
	.CLK(CLK),
	.reset(reset),
	.cmdReq(cmdReq),
	.cmdAck(cmdAck),
	.rspReq(rspReq),
	.rspAck(rspAck),
	.doutA(doutA),
	.doutB(doutB)
);

// File: hdl/regAccessTop.sv
`timescale 1ns/1ps

module regAccessTop (
	input logic CLK,
	input logic reset,
	input logic cmdReq,
	output logic cmdAck,
	input logic [regFilePkg::wordWidth-1:0] dataIn,
	input logic [regFilePkg::wordWidth-1:0] aluResult,
	input logic [regFilePkg::wordWidth-1:0] pcNext,
	input logic enA,
	input logic weA,
	input regFilePkg::regAddr argA,
	input regFilePkg::addrSelA addrSelA,
	input regFilePkg::dataSelA dataSelA,
	input regFilePkg::byteLanes byteEnA,
	input logic enB,
	input logic weB,
	input regFilePkg::regAddr argB,
	input regFilePkg::addrSelB addrSelB,
	input regFilePkg::byteLanes byteEnB,
	output logic rspReq,
	input logic rspAck,
	output logic [regFilePkg::wordWidth-1:0] doutA,
	output logic [regFilePkg::wordWidth-1:0] doutB
);

	// resolved command passed from operand selection to register access.
	regCmdIf cmdBus ();

	operandSelect selectStage_i (
		.CLK(CLK),
		.reset(reset),
		.cmdReq(cmdReq),
		.cmdAck(cmdAck),
		.dataIn(dataIn),
		.aluResult(aluResult),
		.pcNext(pcNext),
		.enA(enA),
		.weA(weA),
		.argA(argA),
		.addrSelA(addrSelA),
		.dataSelA(dataSelA),
		.byteEnA(byteEnA),
		.enB(enB),
		.weB(weB),
		.argB(argB),
		.addrSelB(addrSelB),
		.byteEnB(byteEnB),
		.cmd(cmdBus.source)
	);

	registerFile storageStage_i (
		.CLK(CLK),
		.reset(reset),
		.cmd(cmdBus.sink),
		.rspReq(rspReq),
		.rspAck(rspAck),
		.doutA(doutA),
		.doutB(doutB)
	);

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input logic CLK,
	input logic reset,
	regCmdIf.sink cmd,
	output logic rspReq,
	input logic rspAck,
	output logic [regFilePkg::wordWidth-1:0] doutA,
	output logic [regFilePkg::wordWidth-1:0] doutB
);
	import regFilePkg::*;

	logic [wordWidth-1:0] regs [16];
	logic pending;
	logic accept;
	logic [wordWidth-1:0] afterA;
	logic [wordWidth-1:0] baseB;
	logic [wordWidth-1:0] afterB;
	logic [wordWidth-1:0] readA;

	// replaces only the byte lanes that are enabled.
	function automatic logic [wordWidth-1:0] mergeLanes(
		input logic [wordWidth-1:0] oldWord,
		input logic [wordWidth-1:0] newWord,
		input byteLanes lanes
	);
		logic [wordWidth-1:0] mask;
		mask = {{(wordWidth / 2){lanes[1]}}, {(wordWidth / 2){lanes[0]}}};
		return (oldWord & ~mask) | (newWord & mask);
	endfunction

	// a new command is taken only once the previous response handshake has fully closed.
	assign accept = cmd.req && !cmd.ack && !pending;

	// ******************************
	// post-write values
	// ******************************

	// port A writes first.
	assign afterA = cmd.weA ? mergeLanes(regs[cmd.addrA], cmd.writeDataA, cmd.byteEnA)
		: regs[cmd.addrA];

	// port B builds on the port A result when both hit the same register.
	assign baseB = (cmd.weA && cmd.addrA == cmd.addrB) ? afterA : regs[cmd.addrB];
	assign afterB = cmd.weB ? mergeLanes(baseB, cmd.writeDataB, cmd.byteEnB) : baseB;

	// port B wins a same-register conflict, so port A reads its value too.
	assign readA = (cmd.weB && cmd.addrA == cmd.addrB) ? afterB : afterA;

	// ******************************
	// storage and outputs
	// ******************************

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
			doutA <= '0;
			doutB <= '0;
		end else if (accept) begin
			if (cmd.weA) begin
				regs[cmd.addrA] <= afterA;
			end
			// the later assignment takes precedence on a shared address.
			if (cmd.weB) begin
				regs[cmd.addrB] <= afterB;
			end
			if (cmd.enA) begin
				doutA <= readA;
			end
			if (cmd.enB) begin
				doutB <= afterB;
			end
		end
	end

	// ******************************
	// handshakes
	// ******************************

	always_ff @(posedge CLK) begin
		if (reset) begin
			cmd.ack <= 1'b0;
			rspReq <= 1'b0;
			pending <= 1'b0;
		end else begin
			if (accept) begin
				cmd.ack <= 1'b1;
			end else if (!cmd.req) begin
				cmd.ack <= 1'b0;
			end

			if (accept) begin
				rspReq <= 1'b1;
			end else if (rspAck) begin
				rspReq <= 1'b0;
			end

			// the response stays pending until rspAck has been seen low again.
			if (accept) begin
				pending <= 1'b1;
			end else if (!rspReq && !rspAck) begin
				pending <= 1'b0;
			end
		end
	end

endmodule

// File: hdl/operandSelect.sv
`timescale 1ns/1ps

module operandSelect (
	input logic CLK,
	input logic reset,
	input logic cmdReq,
	output logic cmdAck,
	input logic [regFilePkg::wordWidth-1:0] dataIn,
	input logic [regFilePkg::wordWidth-1:0] aluResult,
	input logic [regFilePkg::wordWidth-1:0] pcNext,
	input logic enA,
	input logic weA,
	input regFilePkg::regAddr argA,
	input regFilePkg::addrSelA addrSelA,
	input regFilePkg::dataSelA dataSelA,
	input regFilePkg::byteLanes byteEnA,
	input logic enB,
	input logic weB,
	input regFilePkg::regAddr argB,
	input regFilePkg::addrSelB addrSelB,
	input regFilePkg::byteLanes byteEnB,
	regCmdIf.source cmd
);
	import regFilePkg::*;

	logic accept;
	regAddr addrANext;
	regAddr addrBNext;
	logic [wordWidth-1:0] writeDataANext;

	// the output register is free only after the second stage has also dropped ack,
	// so a new req never overlaps the tail of the previous handshake.
	assign accept = cmdReq && !cmdAck && !cmd.req && !cmd.ack;

	// ******************************
	// operand resolution
	// ******************************

	always_comb begin
		case (addrSelA)
			raSel: addrANext = regRa;
			rbSel: addrANext = regRb;
			rlSel: addrANext = regRl;
			default: addrANext = argA;
		endcase
	end

	always_comb begin
		case (addrSelB)
			rbSelB: addrBNext = regRb;
			rspSel: addrBNext = regRsp;
			rfpSel: addrBNext = regRfp;
			rrsSel: addrBNext = regRrs;
			default: addrBNext = argB;
		endcase
	end

	always_comb begin
		case (dataSelA)
			// the high byte of the bus is moved down into the low lane.
			dinHighSel: writeDataANext = {{(wordWidth / 2){1'b0}}, dataIn[wordWidth-1:wordWidth/2]};
			pcNextSel: writeDataANext = pcNext;
			aluSel: writeDataANext = aluResult;
			default: writeDataANext = dataIn;
		endcase
	end

	// ******************************
	// handshakes
	// ******************************

	always_ff @(posedge CLK) begin
		if (reset) begin
			cmdAck <= 1'b0;
			cmd.req <= 1'b0;
		end else begin
			if (accept) begin
				cmdAck <= 1'b1;
			end else if (!cmdReq) begin
				cmdAck <= 1'b0;
			end

			if (accept) begin
				cmd.req <= 1'b1;
			end else if (cmd.ack) begin
				cmd.req <= 1'b0;
			end
		end
	end

	// the resolved command is held until the next accept.
	// write enables are folded with the port enables here.
	always_ff @(posedge CLK) begin
		if (accept) begin
			cmd.addrA <= addrANext;
			cmd.enA <= enA;
			cmd.weA <= enA & weA;
			cmd.byteEnA <= byteEnA;
			cmd.writeDataA <= writeDataANext;
			cmd.addrB <= addrBNext;
			cmd.enB <= enB;
			cmd.weB <= enB & weB;
			cmd.byteEnB <= byteEnB;
			cmd.writeDataB <= aluResult;
		end
	end

endmodule

// File: hdl/regCmdIf.sv
`timescale 1ns/1ps

interface regCmdIf;
	import regFilePkg::*;

	// four-phase handshake between the two pipeline stages.
	logic req;
	logic ack;

	// port A of the resolved command.
	regAddr addrA;
	logic enA;
	logic weA;
	byteLanes byteEnA;
	logic [wordWidth-1:0] writeDataA;

	// port B of the resolved command.
	regAddr addrB;
	logic enB;
	logic weB;
	byteLanes byteEnB;
	logic [wordWidth-1:0] writeDataB;

	modport source (output req, addrA, enA, weA, byteEnA, writeDataA,
		addrB, enB, weB, byteEnB, writeDataB, input ack);

	modport sink (input req, addrA, enA, weA, byteEnA, writeDataA,
		addrB, enB, weB, byteEnB, writeDataB, output ack);

endinterface

// File: hdl/regFilePkg.sv
package regFilePkg;

	// ******************************
	// word and register numbering
	// ******************************

	// the byte-lane layout assumes two 8-bit lanes per word.
	localparam int wordWidth = 16;

	typedef logic [3:0] regAddr;

	// fixed role registers of the stack machine.
	localparam regAddr regRa  = 4'd1;
	localparam regAddr regRb  = 4'd2;
	localparam regAddr regRl  = 4'd3;
	localparam regAddr regRsp = 4'd13;
	localparam regAddr regRfp = 4'd14;
	localparam regAddr regRrs = 4'd15;

	// ******************************
	// selector codes
	// ******************************

	// write source for port A.
	typedef enum logic [1:0] {
		dinSel     = 2'd0,
		dinHighSel = 2'd1,
		pcNextSel  = 2'd2,
		aluSel     = 2'd3
	} dataSelA;

	// address source for port A.
	typedef enum logic [1:0] {
		argASel = 2'd0,
		raSel   = 2'd1,
		rbSel   = 2'd2,
		rlSel   = 2'd3
	} addrSelA;

	// address source for port B; unused codes fall back to the argument field.
	typedef enum logic [2:0] {
		argBSel = 3'd0,
		rbSelB  = 3'd1,
		rspSel  = 3'd2,
		rfpSel  = 3'd3,
		rrsSel  = 3'd4
	} addrSelB;

	// bit 1 enables the high byte, bit 0 the low byte.
	typedef logic [1:0] byteLanes;

endpackage
